// File: spi_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////
// SPI bus timing
////////////////////////////////////////////////////////////

package spi_pkg;

	// CLK50MHZ cycles per SCK half period, 4 gives 6.25 MHz
	localparam int unsigned SCK_HALF = 4;

	// CLK50MHZ cycles with chip select high between two frames
	localparam int unsigned CS_GUARD = 2;

	// Divider counter runs 0 .. SCK_HALF-1
	// Keep at least one bit when SCK_HALF is 1
	localparam int unsigned SCK_CNT_W = (SCK_HALF > 1) ? $clog2(SCK_HALF) : 1;

endpackage

`default_nettype wire

// File: xfer_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////
// Transfer word shared by client side and shifter
////////////////////////////////////////////////////////////

package xfer_pkg;

	// Bits per SPI frame
	localparam int unsigned WORD_W = 32;

	// One command or response word, MSB goes out first
	typedef logic [WORD_W-1:0] word_t;

endpackage

`default_nettype wire

// File: spi_if.sv
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////
// Clock generator to shifter
////////////////////////////////////////////////////////////

interface spi_strobe_if;
	// Divider enable, high for the whole frame
	logic run;
	// Free running SCK level, low while run is low
	logic sck_phase;
	// Pulse on falling phase, plus one leading pulse after run rises
	logic write_trig;
	// Pulse on rising phase
	logic read_trig;

	modport gen (input run, output sck_phase, output write_trig, output read_trig);
	modport shifter (output run, input sck_phase, input write_trig, input read_trig);
endinterface

////////////////////////////////////////////////////////////
// Controller to shifter
////////////////////////////////////////////////////////////

interface spi_word_if;
	// Word to send, sampled with trig
	xfer_pkg::word_t data_in;
	// Start of one frame, only while the shifter waits
	logic trig;
	// Received word, valid together with done
	xfer_pkg::word_t data_out;
	// End of frame strobe
	logic done;

	modport ctrl (output data_in, output trig, input data_out, input done);
	modport shifter (input data_in, input trig, output data_out, output done);
endinterface

`default_nettype wire

// File: spi_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module spi_clock_gen (
	input  logic   CLK50MHZ,
	input  logic   RST,
	spi_strobe_if.gen strobe
);

	logic [spi_pkg::SCK_CNT_W-1:0] cnt;
	logic run_d;
	logic term;

	// Last cycle of the current SCK half period
	assign term = (cnt == spi_pkg::SCK_CNT_W'(spi_pkg::SCK_HALF - 1));

	// Run edge detect for the leading write strobe
	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			run_d <= 1'b0;
		end else begin
			run_d <= strobe.run;
		end
	end

	////////////////////////////////////////////////////////////
	// Divider and strobes
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			cnt              <= '0;
			strobe.sck_phase <= 1'b0;
			strobe.write_trig <= 1'b0;
			strobe.read_trig <= 1'b0;
		end else if (!strobe.run) begin
			// Parked low between frames
			cnt              <= '0;
			strobe.sck_phase <= 1'b0;
			strobe.write_trig <= 1'b0;
			strobe.read_trig <= 1'b0;
		end else begin
			if (term) begin
				cnt              <= '0;
				strobe.sck_phase <= ~strobe.sck_phase;
			end else begin
				cnt <= cnt + 1'b1;
			end
			// Leading pulse sets up the MSB before the first rising edge
			strobe.write_trig <= !run_d || (term && strobe.sck_phase);
			strobe.read_trig  <= term && !strobe.sck_phase;
		end
	end

	// Setup and sample points must never collide
	assert property (@(posedge CLK50MHZ) disable iff (RST)
		!(strobe.write_trig && strobe.read_trig))
	else $error("write_trig and read_trig high in the same cycle");

endmodule

`default_nettype wire

// File: spi_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module spi_shifter #(
	parameter int WIDTH = 32
) (
	input  logic     CLK50MHZ,
	input  logic     RST,
	spi_strobe_if.shifter strobe,
	spi_word_if.shifter   word,
	output logic     spi_sck,
	output logic     spi_cs,
	output logic     spi_mosi,
	input  logic     spi_miso
);

	typedef enum logic [1:0] {
		ST_WAIT,
		ST_SEND,
		ST_DONE,
		ST_GUARD
	} state_t;

	state_t state;

	// Counts write strobes, WIDTH of them carry data and one ends the frame
	logic [$clog2(WIDTH+1)-1:0] bit_idx;
	logic [$clog2(spi_pkg::CS_GUARD+1)-1:0] guard_cnt;
	logic [WIDTH-1:0] tx_reg;
	logic [WIDTH-1:0] rx_reg;
	logic last_bit;

	assign last_bit = (bit_idx == $bits(bit_idx)'(WIDTH));

	assign strobe.run    = (state == ST_SEND);
	assign word.done     = (state == ST_DONE);
	assign word.data_out = rx_reg;

	// SCK only toggles inside the frame
	assign spi_sck = strobe.sck_phase && (state == ST_SEND);

	////////////////////////////////////////////////////////////
	// Frame control
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state     <= ST_WAIT;
			bit_idx   <= '0;
			guard_cnt <= '0;
			spi_cs    <= 1'b1;
			spi_mosi  <= 1'b0;
		end else begin
			case (state)
				ST_WAIT: begin
					if (word.trig) begin
						state   <= ST_SEND;
						bit_idx <= '0;
						spi_cs  <= 1'b0;
					end
				end
				ST_SEND: begin
					if (strobe.write_trig) begin
						if (last_bit) begin
							// Falling edge after the last bit, line back to idle
							state    <= ST_DONE;
							spi_mosi <= 1'b0;
						end else begin
							spi_mosi <= tx_reg[WIDTH-1];
							bit_idx  <= bit_idx + 1'b1;
						end
					end
				end
				ST_DONE: begin
					state     <= ST_GUARD;
					guard_cnt <= '0;
					spi_cs    <= 1'b1;
				end
				ST_GUARD: begin
					if (guard_cnt == $bits(guard_cnt)'(spi_pkg::CS_GUARD - 1)) begin
						state <= ST_WAIT;
					end else begin
						guard_cnt <= guard_cnt + 1'b1;
					end
				end
				default: state <= ST_WAIT;
			endcase
		end
	end

	// Shift registers
	always_ff @(posedge CLK50MHZ) begin
		if (state == ST_WAIT && word.trig) begin
			tx_reg <= word.data_in;
		end else if (state == ST_SEND && strobe.write_trig && !last_bit) begin
			tx_reg <= {tx_reg[WIDTH-2:0], 1'b0};
		end
		if (state == ST_SEND && strobe.read_trig) begin
			rx_reg <= {rx_reg[WIDTH-2:0], spi_miso};
		end
	end

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////

	assert property (@(posedge CLK50MHZ) disable iff (RST) spi_cs |-> !spi_sck)
	else $error("SCK high while chip select is high");

	assert property (@(posedge CLK50MHZ) disable iff (RST) word.done |=> !word.done)
	else $error("done longer than one cycle");

	// Controller must respect the guard time
	assert property (@(posedge CLK50MHZ) disable iff (RST) word.trig |-> state == ST_WAIT)
	else $error("trig while the shifter is not waiting");

endmodule

`default_nettype wire

// File: spi_xfer_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module spi_xfer_ctrl (
	input  logic            CLK50MHZ,
	input  logic            RST,
	input  logic            cmd_valid,
	input  xfer_pkg::word_t cmd_data,
	output logic            cmd_ready,
	output logic            rsp_valid,
	output xfer_pkg::word_t rsp_data,
	input  logic            rsp_ready,
	spi_word_if.ctrl        word
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_BUSY,
		ST_RESP
	} state_t;

	state_t state;
	xfer_pkg::word_t cmd_word;

	// One transfer in flight at a time
	assign cmd_ready = (state == ST_IDLE);
	assign rsp_valid = (state == ST_RESP);

	assign word.data_in = cmd_word;

	////////////////////////////////////////////////////////////
	// Handshake state machine
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK50MHZ) begin
		if (RST) begin
			state     <= ST_IDLE;
			word.trig <= 1'b0;
		end else begin
			word.trig <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (cmd_valid) begin
						state     <= ST_BUSY;
						word.trig <= 1'b1;
					end
				end
				ST_BUSY: begin
					if (word.done) begin
						state <= ST_RESP;
					end
				end
				ST_RESP: begin
					if (rsp_ready) begin
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// Command word and response word
	always_ff @(posedge CLK50MHZ) begin
		if (state == ST_IDLE && cmd_valid) begin
			cmd_word <= cmd_data;
		end
		if (state == ST_BUSY && word.done) begin
			rsp_data <= word.data_out;
		end
	end

	// Response must hold under back-pressure
	assert property (@(posedge CLK50MHZ) disable iff (RST)
		rsp_valid && !rsp_ready |=> $stable(rsp_data))
	else $error("rsp_data changed while the response was stalled");

endmodule

`default_nettype wire

// File: spi_master_top.sv
`timescale 1ns/1ps
`default_nettype none

module spi_master_top (
	input  logic            CLK50MHZ,
	input  logic            RST,
	// Command channel
	input  logic            cmd_valid,
	input  xfer_pkg::word_t cmd_data,
	output logic            cmd_ready,
	// Response channel
	output logic            rsp_valid,
	output xfer_pkg::word_t rsp_data,
	input  logic            rsp_ready,
	// SPI pins, mode 0
	output logic            spi_sck,
	output logic            spi_cs,
	output logic            spi_mosi,
	input  logic            spi_miso
);

	spi_strobe_if strobe_bus ();
	spi_word_if   word_bus ();

	////////////////////////////////////////////////////////////
	// Blocks
	////////////////////////////////////////////////////////////

	spi_clock_gen i_spi_clock_gen (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.strobe   (strobe_bus.gen)
	);

	spi_shifter #(
		.WIDTH (xfer_pkg::WORD_W)
	) i_spi_shifter (
		.CLK50MHZ (CLK50MHZ),
		.RST      (RST),
		.strobe   (strobe_bus.shifter),
		.word     (word_bus.shifter),
		.spi_sck  (spi_sck),
		.spi_cs   (spi_cs),
		.spi_mosi (spi_mosi),
		.spi_miso (spi_miso)
	);

	spi_xfer_ctrl i_spi_xfer_ctrl (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.cmd_valid (cmd_valid),
		.cmd_data  (cmd_data),
		.cmd_ready (cmd_ready),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data),
		.rsp_ready (rsp_ready),
		.word      (word_bus.ctrl)
	);

endmodule

`default_nettype wire

// File: tb_spi_slave.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_slave (
	input  logic            RST,
	input  logic            spi_sck,
	input  logic            spi_cs,
	input  logic            spi_mosi,
	output logic            spi_miso,
	output xfer_pkg::word_t frame_word,
	output int              frame_count,
	output int              framing_errors
);

	xfer_pkg::word_t tx_word;
	xfer_pkg::word_t rx_word;
	xfer_pkg::word_t prev_word;
	int unsigned rise_cnt;
	logic sck_q;
	logic cs_q;

	// Mode 0, the bit on the line is always the MSB of the shift register
	assign spi_miso = tx_word[xfer_pkg::WORD_W-1];

	initial begin
		tx_word        = '0;
		rx_word        = '0;
		prev_word      = '0;
		frame_word     = '0;
		frame_count    = 0;
		framing_errors = 0;
		rise_cnt       = 0;
		sck_q          = 1'b0;
		cs_q           = 1'b1;
		forever begin
			@(spi_sck or spi_cs or RST);
			if (!RST) begin
				// Chip select falls, reply with the word of the last frame
				if (cs_q && !spi_cs) begin
					tx_word  = prev_word;
					rx_word  = '0;
					rise_cnt = 0;
				end
				if (!sck_q && spi_sck) begin
					if (spi_cs) begin
						$display("SCK rose while chip select was high");
						framing_errors = framing_errors + 1;
					end else begin
						rx_word  = {rx_word[xfer_pkg::WORD_W-2:0], spi_mosi};
						rise_cnt = rise_cnt + 1;
					end
				end
				// Next bit goes out on the falling edge
				if (sck_q && !spi_sck && !spi_cs) begin
					tx_word = {tx_word[xfer_pkg::WORD_W-2:0], 1'b0};
				end
				if (!cs_q && spi_cs) begin
					assert (rise_cnt == xfer_pkg::WORD_W)
					else begin
						$display("Frame ended after %0d rising SCK edges instead of %0d",
							rise_cnt, xfer_pkg::WORD_W);
						framing_errors = framing_errors + 1;
					end
					frame_word  = rx_word;
					prev_word   = rx_word;
					frame_count = frame_count + 1;
				end
			end
			sck_q = spi_sck;
			cs_q  = spi_cs;
		end
	end

endmodule

`default_nettype wire

// File: tb_spi_master_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_spi_master_top;

	localparam int unsigned CMD_TIMEOUT = 50;
	// One frame plus guard time and a wide margin
	localparam int unsigned RSP_TIMEOUT =
		4 * spi_pkg::SCK_HALF * (xfer_pkg::WORD_W + 2) + 100;

	logic            CLK50MHZ = 1'b0;
	logic            RST;
	logic            cmd_valid;
	xfer_pkg::word_t cmd_data;
	logic            cmd_ready;
	logic            rsp_valid;
	xfer_pkg::word_t rsp_data;
	logic            rsp_ready;
	logic            spi_sck;
	logic            spi_cs;
	logic            spi_mosi;
	logic            spi_miso;

	xfer_pkg::word_t slave_word;
	int              slave_frames;
	int              slave_errors;

	int              mismatch_errors = 0;
	int              protocol_errors = 0;
	int              other_errors = 0;
	xfer_pkg::word_t prev_cmd = '0;
	logic            timed_out = 1'b0;
	integer          seed = 89;

	always #10 CLK50MHZ = ~CLK50MHZ;

	spi_master_top i_spi_master_top (
		.CLK50MHZ  (CLK50MHZ),
		.RST       (RST),
		.cmd_valid (cmd_valid),
		.cmd_data  (cmd_data),
		.cmd_ready (cmd_ready),
		.rsp_valid (rsp_valid),
		.rsp_data  (rsp_data),
		.rsp_ready (rsp_ready),
		.spi_sck   (spi_sck),
		.spi_cs    (spi_cs),
		.spi_mosi  (spi_mosi),
		.spi_miso  (spi_miso)
	);

	tb_spi_slave i_tb_spi_slave (
		.RST            (RST),
		.spi_sck        (spi_sck),
		.spi_cs         (spi_cs),
		.spi_mosi       (spi_mosi),
		.spi_miso       (spi_miso),
		.frame_word     (slave_word),
		.frame_count    (slave_frames),
		.framing_errors (slave_errors)
	);

	////////////////////////////////////////////////////////////
	// Protocol checks
	////////////////////////////////////////////////////////////

	assert property (@(posedge CLK50MHZ) disable iff (RST) spi_cs |-> !spi_sck)
	else begin
		$display("SCK high while chip select is high");
		protocol_errors = protocol_errors + 1;
	end

	// Stalled response holds
	assert property (@(posedge CLK50MHZ) disable iff (RST)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data))
	else begin
		$display("Response dropped or changed while rsp_ready was low");
		protocol_errors = protocol_errors + 1;
	end

	assert property (@(posedge CLK50MHZ) disable iff (RST) rsp_valid |-> !cmd_ready)
	else begin
		$display("cmd_ready high while a response is pending");
		protocol_errors = protocol_errors + 1;
	end

	// No bus activity under back-pressure
	assert property (@(posedge CLK50MHZ) disable iff (RST)
		rsp_valid && !rsp_ready |-> spi_cs && !spi_sck)
	else begin
		$display("SPI bus active while the response was stalled");
		protocol_errors = protocol_errors + 1;
	end

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic compare_word(input string name, input xfer_pkg::word_t expected,
		input xfer_pkg::word_t actual);
		assert (actual === expected)
		else begin
			$display("Mismatch %s expected %h actual %h", name, expected, actual);
			mismatch_errors = mismatch_errors + 1;
		end
	endtask

	task automatic compare_bit(input string name, input logic expected, input logic actual);
		assert (actual === expected)
		else begin
			$display("Mismatch %s expected %b actual %b", name, expected, actual);
			mismatch_errors = mismatch_errors + 1;
		end
	endtask

	// One command, frame and response, starting on a falling edge
	task automatic run_transfer(input xfer_pkg::word_t data, input int unsigned stall,
		input string name);
		int unsigned cycles;
		int frames_before;
		xfer_pkg::word_t held;
		frames_before = slave_frames;
		cmd_data      = data;
		cmd_valid     = 1'b1;
		rsp_ready     = (stall == 0);
		cycles        = 0;
		while (!cmd_ready && cycles < CMD_TIMEOUT) begin
			@(negedge CLK50MHZ);
			cycles = cycles + 1;
		end
		if (!cmd_ready) begin
			$display("Timeout waiting for cmd_ready in %s", name);
			other_errors = other_errors + 1;
			timed_out    = 1'b1;
			cmd_valid    = 1'b0;
			return;
		end
		@(negedge CLK50MHZ);
		cmd_valid = 1'b0;
		cycles    = 0;
		while (!rsp_valid && cycles < RSP_TIMEOUT) begin
			@(negedge CLK50MHZ);
			cycles = cycles + 1;
		end
		if (!rsp_valid) begin
			$display("Timeout waiting for rsp_valid in %s", name);
			other_errors = other_errors + 1;
			timed_out    = 1'b1;
			return;
		end
		held = rsp_data;
		repeat (stall) @(negedge CLK50MHZ);
		compare_word($sformatf("%s held response", name), prev_cmd, rsp_data);
		rsp_ready = 1'b1;
		@(negedge CLK50MHZ);
		compare_bit($sformatf("%s rsp_valid after handshake", name), 1'b0, rsp_valid);
		// Slave echoes the previous command word
		compare_word($sformatf("%s echo", name), prev_cmd, held);
		compare_word($sformatf("%s mosi word", name), data, slave_word);
		assert (slave_frames == frames_before + 1)
		else begin
			$display("Slave saw %0d frames during %s instead of one",
				slave_frames - frames_before, name);
			other_errors = other_errors + 1;
		end
		prev_cmd = data;
	endtask

	task automatic run_tests();
		xfer_pkg::word_t data;
		int unsigned stall;
		int i;
		run_transfer(32'hA5C3_0F96, 0, "first");
		if (timed_out) return;
		run_transfer(32'h3C5A_96E1, 40, "stall fixed");
		if (timed_out) return;
		for (i = 0; i < 4; i++) begin
			data  = $random(seed);
			stall = $unsigned($random(seed)) % 41;
			run_transfer(data, stall, $sformatf("stall %0d", i));
			if (timed_out) return;
		end
		// Back to back with rsp_ready held high
		for (i = 0; i < 20; i++) begin
			data = $random(seed);
			run_transfer(data, 0, $sformatf("burst %0d", i));
			if (timed_out) return;
		end
	endtask

	task automatic report_and_finish();
		int total;
		total = mismatch_errors + protocol_errors + slave_errors + other_errors;
		$display("Error counts: mismatch %0d, protocol %0d, framing %0d, other %0d",
			mismatch_errors, protocol_errors, slave_errors, other_errors);
		if (total == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		RST       = 1'b1;
		cmd_valid = 1'b0;
		cmd_data  = '0;
		rsp_ready = 1'b0;
		repeat (8) @(negedge CLK50MHZ);
		RST = 1'b0;
		@(negedge CLK50MHZ);
		compare_bit("reset spi_cs", 1'b1, spi_cs);
		compare_bit("reset spi_sck", 1'b0, spi_sck);
		compare_bit("reset rsp_valid", 1'b0, rsp_valid);
		compare_bit("reset cmd_ready", 1'b1, cmd_ready);
		run_tests();
		report_and_finish();
	end

endmodule

`default_nettype wire

// File: spi_master.f
spi_pkg.sv
xfer_pkg.sv
spi_if.sv
spi_clock_gen.sv
spi_shifter.sv
spi_xfer_ctrl.sv
spi_master_top.sv
tb_spi_slave.sv
tb_spi_master_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the SPI master testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module tb_spi_master_top \
	-f spi_master.f \
	-o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Something failed" sim.log; then
	echo "Simulation FAILED"
	exit 1
fi

echo "Simulation PASSED"
